// File: Bender.yml
package:
  name: rect_render

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/renderPkg.sv
      - raster/rectScanner.sv
      - raster/blockGather.sv
      - src/stencilMaskReader.sv
      - src/memWriteSequencer.sv
      - src/renderControl.sv
      - src/rectRenderTop.sv
  - target: test
    include_dirs:
      - common
      - tb
    files:
      - tb/rectRenderTb.sv

// File: common/renderPkg.sv
/*
 * Shared types of the rectangle fill renderer.
 * Modules refer to them by scoped names.
 */
`default_nettype none

`include "render_consts.svh"

package renderPkg;

	// ------------------------------------------------------------
	// Command side
	// ------------------------------------------------------------

	// Rectangle corners are inclusive
	typedef struct packed {
		logic signed [`RENDER_COORD_W-1:0] x0;
		logic signed [`RENDER_COORD_W-1:0] y0;
		logic signed [`RENDER_COORD_W-1:0] x1;
		logic signed [`RENDER_COORD_W-1:0] y1;
		logic        [`RENDER_COLOR_W-1:0] color;
		// Written as bit 15 of every pixel
		logic                              setMask;
	} rectCmd_t;

	typedef struct packed {
		logic [`RENDER_AREA_W-1:0] x0;
		logic [`RENDER_AREA_W-1:0] y0;
		logic [`RENDER_AREA_W-1:0] x1;
		logic [`RENDER_AREA_W-1:0] y1;
	} drawArea_t;

	// ------------------------------------------------------------
	// Scan and memory side
	// ------------------------------------------------------------

	// X is always even, the right pixel sits at X+1
	typedef struct packed {
		logic [`RENDER_AREA_W-1:0]      x;
		logic [`RENDER_AREA_W-1:0]      y;
		logic                           validL;
		logic                           validR;
		logic [`RENDER_BLOCK_ADR_W-1:0] blockAdr;
	} pixelPair_t;

	typedef struct packed {
		logic [`RENDER_BLOCK_ADR_W-1:0] adr;
		logic [`RENDER_BLOCK_W-1:0]     data;
		// One bit per pixel lane
		logic [`RENDER_BLOCK_PIX-1:0]   mask;
	} memReq_t;

endpackage

`default_nettype wire

// File: common/render_consts.svh
/*
 * Widths and geometry of the rectangle fill renderer.
 * Included by the package, the RTL and the testbench.
 */
`ifndef RENDER_CONSTS_SVH
`define RENDER_CONSTS_SVH

// Signed primitive coordinates
`define RENDER_COORD_W 12
// Draw-area register coordinates
`define RENDER_AREA_W 10

// Pixel format, 15-bit color plus mask bit on top
`define RENDER_COLOR_W 15
`define RENDER_PIX_W 16

// VRAM block geometry
`define RENDER_BLOCK_PIX 16
// Nine bits of Y and X/16
`define RENDER_BLOCK_ADR_W 15
`define RENDER_BLOCK_W 256

`endif

// File: raster/blockGather.sv
/*
 * Collects written pixels of one VRAM block into a 256-bit buffer.
 * A write to another block, or a flush, hands the finished block on.
 */
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module blockGather (
	input  wire                               i_clk,
	input  wire                               i_nrst,
	input  wire                               i_start,
	input  wire                               i_writeL,
	input  wire                               i_writeR,
	input  renderPkg::pixelPair_t             i_pair,
	input  wire [`RENDER_COLOR_W-1:0]         i_color,
	input  wire                               i_setMask,
	input  wire                               i_flush,
	output logic                              o_blockDone,
	output renderPkg::memReq_t                o_blockReq
);

	logic [`RENDER_COLOR_W-1:0]     color;
	logic                           setMask;
	logic [`RENDER_BLOCK_ADR_W-1:0] prevAdr;
	logic                           firstBlock;
	logic [`RENDER_BLOCK_W-1:0]     dataBuf, dataNext;
	logic [`RENDER_BLOCK_PIX-1:0]   maskBuf, maskNext;
	logic [3:0]                     laneL;
	logic                           anyWrite, newBlock, emit;

	// Left lane is even, right lane follows it
	assign laneL    = i_pair.x[3:0];
	assign anyWrite = i_writeL || i_writeR;
	assign newBlock = anyWrite && !firstBlock && (i_pair.blockAdr != prevAdr);
	assign emit     = newBlock || (i_flush && (|maskBuf));

	// Start from an empty buffer when the block changes
	always_comb begin
		dataNext = newBlock ? '0 : dataBuf;
		maskNext = newBlock ? '0 : maskBuf;
		if (i_flush) begin
			maskNext = '0;
		end
		if (i_writeL) begin
			dataNext[laneL*`RENDER_PIX_W +: `RENDER_PIX_W] = {setMask, color};
			maskNext[laneL] = 1'b1;
		end
		if (i_writeR) begin
			dataNext[(laneL+4'd1)*`RENDER_PIX_W +: `RENDER_PIX_W] = {setMask, color};
			maskNext[laneL+4'd1] = 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			firstBlock  <= 1'b1;
			maskBuf     <= '0;
			o_blockDone <= 1'b0;
		end else begin
			o_blockDone <= emit;
			maskBuf     <= i_start ? '0 : maskNext;
			if (i_start) begin
				firstBlock <= 1'b1;
			end else if (anyWrite) begin
				firstBlock <= 1'b0;
			end
		end
	end

	// Payload side
	always_ff @(posedge i_clk) begin
		dataBuf <= dataNext;
		if (i_start) begin
			color   <= i_color;
			setMask <= i_setMask;
		end
		if (anyWrite) begin
			prevAdr <= i_pair.blockAdr;
		end
		if (emit) begin
			o_blockReq.adr  <= prevAdr;
			o_blockReq.data <= dataBuf;
			o_blockReq.mask <= maskBuf;
		end
	end

endmodule

`default_nettype wire

// File: raster/rectScanner.sv
/*
 * Clips the rectangle to the draw area and walks it two pixels at a time.
 * Load latches the command, advance steps one pair or wraps to the next row.
 */
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module rectScanner (
	input  wire                                  i_clk,
	input  wire                                  i_nrst,
	input  wire                                  i_load,
	input  wire                                  i_advance,
	input  renderPkg::rectCmd_t                  i_cmd,
	input  renderPkg::drawArea_t                 i_area,
	output renderPkg::pixelPair_t                o_pair,
	output logic [`RENDER_BLOCK_ADR_W-1:0]       o_nextBlockAdr,
	output logic                                 o_rowEnd,
	output logic                                 o_rectEnd,
	output logic                                 o_empty
);

	// Draw area widened to signed coordinates
	logic signed [`RENDER_COORD_W-1:0] areaX0, areaY0, areaX1, areaY1;
	logic signed [`RENDER_COORD_W-1:0] clipX0, clipY0, clipX1, clipY1;

	// Latched clip window and scan position
	logic signed [`RENDER_COORD_W-1:0] leftX, minX, maxX, maxY;
	logic signed [`RENDER_COORD_W-1:0] curX, curY;
	logic signed [`RENDER_COORD_W-1:0] rightX, stepX, nextX, nextY;
	logic                              emptyR;

	assign areaX0 = signed'({2'b00, i_area.x0});
	assign areaY0 = signed'({2'b00, i_area.y0});
	assign areaX1 = signed'({2'b00, i_area.x1});
	assign areaY1 = signed'({2'b00, i_area.y1});

	// Intersection of rectangle and draw area
	assign clipX0 = (i_cmd.x0 > areaX0) ? i_cmd.x0 : areaX0;
	assign clipY0 = (i_cmd.y0 > areaY0) ? i_cmd.y0 : areaY0;
	assign clipX1 = (i_cmd.x1 < areaX1) ? i_cmd.x1 : areaX1;
	assign clipY1 = (i_cmd.y1 < areaY1) ? i_cmd.y1 : areaY1;

	// ------------------------------------------------------------
	// Pair stepping
	// ------------------------------------------------------------
	assign rightX = curX + 12'sd1;
	assign stepX  = curX + 12'sd2;

	// Last pair of the row once the next pair starts past the right edge
	assign o_rowEnd  = (stepX > maxX);
	assign o_rectEnd = o_rowEnd && (curY >= maxY);

	assign nextX = o_rowEnd ? leftX : stepX;
	assign nextY = o_rowEnd ? (curY + 12'sd1) : curY;

	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			emptyR <= 1'b1;
			curX   <= '0;
			curY   <= '0;
		end else if (i_load) begin
			emptyR <= (clipX1 < clipX0) || (clipY1 < clipY0);
			// Start on the even pixel at or left of the clipped edge
			curX   <= {clipX0[`RENDER_COORD_W-1:1], 1'b0};
			curY   <= clipY0;
		end else if (i_advance) begin
			curX <= nextX;
			curY <= nextY;
		end
	end

	// Window registers only matter while a rectangle is loaded
	always_ff @(posedge i_clk) begin
		if (i_load) begin
			leftX <= {clipX0[`RENDER_COORD_W-1:1], 1'b0};
			minX  <= clipX0;
			maxX  <= clipX1;
			maxY  <= clipY1;
		end
	end

	assign o_empty = emptyR;

	// ------------------------------------------------------------
	// Pair outputs
	// ------------------------------------------------------------
	assign o_pair.x        = curX[`RENDER_AREA_W-1:0];
	assign o_pair.y        = curY[`RENDER_AREA_W-1:0];
	assign o_pair.validL   = (curX >= minX) && (curX <= maxX);
	assign o_pair.validR   = (rightX >= minX) && (rightX <= maxX);
	assign o_pair.blockAdr = {curY[8:0], curX[9:4]};

	// Block the pair of the next cycle falls in, for the stencil lookahead
	assign o_nextBlockAdr = i_advance ? {nextY[8:0], nextX[9:4]} : o_pair.blockAdr;

endmodule

`default_nettype wire

// File: src/memWriteSequencer.sv
/*
 * Holds one finished block as a memory write until the port accepts it.
 * Busy back-pressure from here pauses the scan.
 */
`timescale 1ns/1ps
`default_nettype none

module memWriteSequencer (
	input  wire                   i_clk,
	input  wire                   i_nrst,
	input  wire                   i_blockDone,
	input  renderPkg::memReq_t    i_blockReq,
	input  wire                   i_busy,
	output logic                  o_command,
	output logic                  o_write,
	output renderPkg::memReq_t    o_memReq,
	output logic                  o_seqBusy,
	output logic                  o_idle
);

	typedef enum logic {
		SEQ_IDLE  = 1'b0,
		SEQ_ISSUE = 1'b1
	} seqState_t;

	seqState_t currState, nextState;

	// ------------------------------------------------------------
	// State machine
	// ------------------------------------------------------------
	always_comb begin
		nextState = currState;
		case (currState)
			SEQ_IDLE: begin
				if (i_blockDone) begin
					nextState = SEQ_ISSUE;
				end
			end
			SEQ_ISSUE: begin
				// Accepted when the port is free
				if (!i_busy) begin
					nextState = SEQ_IDLE;
				end
			end
			default: nextState = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			currState <= SEQ_IDLE;
		end else begin
			currState <= nextState;
		end
	end

	// Request is frozen while the command is out
	always_ff @(posedge i_clk) begin
		if ((currState == SEQ_IDLE) && i_blockDone) begin
			o_memReq <= i_blockReq;
		end
	end

	assign o_command = (currState == SEQ_ISSUE);
	// Only writes leave this unit
	assign o_write   = o_command;

	// A block arriving now also counts, so nothing can overrun it
	assign o_seqBusy = (currState == SEQ_ISSUE) || i_blockDone;
	assign o_idle    = (currState == SEQ_IDLE) && !i_blockDone;

endmodule

`default_nettype wire

// File: src/rectRenderTop.sv
/*
 * Rectangle fill renderer top level.
 * Connects scanner, stencil reader, gather unit, write sequencer and FSM.
 */
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module rectRenderTop (
	input  wire                                  i_clk,
	input  wire                                  i_nrst,
	input  wire                                  i_start,
	input  renderPkg::rectCmd_t                  i_cmd,
	input  renderPkg::drawArea_t                 i_area,
	input  wire                                  i_checkMask,
	output logic                                 o_active,
	// Stencil side
	output logic                                 o_stencilReadSig,
	output logic [`RENDER_BLOCK_ADR_W-1:0]       o_stencilReadAdr,
	input  wire [`RENDER_BLOCK_PIX-1:0]          i_stencilReadValue,
	// Memory side
	output logic                                 o_command,
	output logic                                 o_write,
	output renderPkg::memReq_t                   o_memReq,
	input  wire                                  i_busy
);

	renderPkg::pixelPair_t          pair;
	renderPkg::memReq_t             blockReq;
	logic [`RENDER_BLOCK_ADR_W-1:0] nextBlockAdr;
	logic load, advance, readReq, writeL, writeR, flush;
	logic rowEnd, rectEnd, empty;
	logic maskL, maskR;
	logic blockDone, seqBusy, seqIdle;

	rectScanner i_rectScanner (
		.i_clk          (i_clk),
		.i_nrst         (i_nrst),
		.i_load         (load),
		.i_advance      (advance),
		.i_cmd          (i_cmd),
		.i_area         (i_area),
		.o_pair         (pair),
		.o_nextBlockAdr (nextBlockAdr),
		.o_rowEnd       (rowEnd),
		.o_rectEnd      (rectEnd),
		.o_empty        (empty)
	);

	stencilMaskReader i_stencilMaskReader (
		.i_clk              (i_clk),
		.i_nrst             (i_nrst),
		.i_readReq          (readReq),
		.i_nextBlockAdr     (nextBlockAdr),
		.i_pixX             (pair.x),
		.i_stencilReadValue (i_stencilReadValue),
		.o_stencilReadSig   (o_stencilReadSig),
		.o_stencilReadAdr   (o_stencilReadAdr),
		.o_maskL            (maskL),
		.o_maskR            (maskR)
	);

	// Color and mask bit are latched on the start strobe
	blockGather i_blockGather (
		.i_clk       (i_clk),
		.i_nrst      (i_nrst),
		.i_start     (load),
		.i_writeL    (writeL),
		.i_writeR    (writeR),
		.i_pair      (pair),
		.i_color     (i_cmd.color),
		.i_setMask   (i_cmd.setMask),
		.i_flush     (flush),
		.o_blockDone (blockDone),
		.o_blockReq  (blockReq)
	);

	memWriteSequencer i_memWriteSequencer (
		.i_clk       (i_clk),
		.i_nrst      (i_nrst),
		.i_blockDone (blockDone),
		.i_blockReq  (blockReq),
		.i_busy      (i_busy),
		.o_command   (o_command),
		.o_write     (o_write),
		.o_memReq    (o_memReq),
		.o_seqBusy   (seqBusy),
		.o_idle      (seqIdle)
	);

	renderControl i_renderControl (
		.i_clk        (i_clk),
		.i_nrst       (i_nrst),
		.i_start      (i_start),
		.i_empty      (empty),
		.i_rowEnd     (rowEnd),
		.i_rectEnd    (rectEnd),
		.i_pairValidL (pair.validL),
		.i_pairValidR (pair.validR),
		.i_maskL      (maskL),
		.i_maskR      (maskR),
		.i_checkMask  (i_checkMask),
		.i_seqBusy    (seqBusy),
		.i_seqIdle    (seqIdle),
		.o_load       (load),
		.o_advance    (advance),
		.o_readReq    (readReq),
		.o_writeL     (writeL),
		.o_writeR     (writeR),
		.o_flush      (flush),
		.o_active     (o_active)
	);

endmodule

`default_nettype wire

// File: src/renderControl.sv
/*
 * Render FSM: accepts a start, scans the rectangle pair by pair,
 * then flushes the last block and waits for the memory side to drain.
 */
`timescale 1ns/1ps
`default_nettype none

module renderControl (
	input  wire   i_clk,
	input  wire   i_nrst,
	input  wire   i_start,
	input  wire   i_empty,
	input  wire   i_rowEnd,
	input  wire   i_rectEnd,
	input  wire   i_pairValidL,
	input  wire   i_pairValidR,
	input  wire   i_maskL,
	input  wire   i_maskR,
	input  wire   i_checkMask,
	input  wire   i_seqBusy,
	input  wire   i_seqIdle,
	output logic  o_load,
	output logic  o_advance,
	output logic  o_readReq,
	output logic  o_writeL,
	output logic  o_writeR,
	output logic  o_flush,
	output logic  o_active
);

	typedef enum logic [2:0] {
		RENDER_WAIT    = 3'd0,
		RECT_START     = 3'd1,
		RECT_SCAN_LINE = 3'd2,
		FLUSH_SEND     = 3'd3,
		FLUSH_COMPLETE = 3'd4
	} renderState_t;

	renderState_t currState, nextState;
	logic         checkMask;
	logic         keepL, keepR;

	// Mask check flag sampled with the command
	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			checkMask <= 1'b0;
		end else if (o_load) begin
			checkMask <= i_checkMask;
		end
	end

	// Masked pixels are kept out when checking is on
	assign keepL = i_pairValidL && !(checkMask && i_maskL);
	assign keepR = i_pairValidR && !(checkMask && i_maskR);

	// ------------------------------------------------------------
	// Next state and strobes
	// ------------------------------------------------------------
	always_comb begin
		nextState = currState;
		o_load    = 1'b0;
		o_advance = 1'b0;
		o_readReq = 1'b0;
		o_writeL  = 1'b0;
		o_writeR  = 1'b0;
		o_flush   = 1'b0;
		case (currState)
			RENDER_WAIT: begin
				o_load = i_start;
				if (i_start) begin
					nextState = RECT_START;
				end
			end
			RECT_START: begin
				if (i_empty) begin
					// Nothing to draw, just pass through the drain check
					nextState = FLUSH_COMPLETE;
				end else begin
					// Stencil of the first pair
					o_readReq = 1'b1;
					nextState = RECT_SCAN_LINE;
				end
			end
			RECT_SCAN_LINE: begin
				// No lookahead read past the last pair
				o_readReq = !(i_rectEnd && !i_seqBusy);
				if (!i_seqBusy) begin
					o_writeL  = keepL;
					o_writeR  = keepR;
					o_advance = 1'b1;
					if (i_rectEnd) begin
						nextState = FLUSH_SEND;
					end
				end
			end
			FLUSH_SEND: begin
				if (!i_seqBusy) begin
					o_flush   = 1'b1;
					nextState = FLUSH_COMPLETE;
				end
			end
			FLUSH_COMPLETE: begin
				if (i_seqIdle) begin
					nextState = RENDER_WAIT;
				end
			end
			default: nextState = RENDER_WAIT;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			currState <= RENDER_WAIT;
		end else begin
			currState <= nextState;
		end
	end

	assign o_active = (currState != RENDER_WAIT);

endmodule

`default_nettype wire

// File: src/stencilMaskReader.sv
/*
 * Reads the stencil word of each new block and selects the pair's mask bits.
 * The word is used on the cycle it returns and kept for the rest of the block.
 */
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module stencilMaskReader (
	input  wire                                  i_clk,
	input  wire                                  i_nrst,
	input  wire                                  i_readReq,
	input  wire [`RENDER_BLOCK_ADR_W-1:0]        i_nextBlockAdr,
	input  wire [`RENDER_AREA_W-1:0]             i_pixX,
	input  wire [`RENDER_BLOCK_PIX-1:0]          i_stencilReadValue,
	output logic                                 o_stencilReadSig,
	output logic [`RENDER_BLOCK_ADR_W-1:0]       o_stencilReadAdr,
	output logic                                 o_maskL,
	output logic                                 o_maskR
);

	logic [`RENDER_BLOCK_ADR_W-1:0] curAdr;
	logic                           curValid;
	logic                           readPending;
	logic [`RENDER_BLOCK_PIX-1:0]   stencilStore, stencilMux;
	logic [3:0]                     lane;

	// Only a block change costs a read
	assign o_stencilReadSig = i_readReq && (!curValid || (i_nextBlockAdr != curAdr));
	assign o_stencilReadAdr = i_nextBlockAdr;

	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			curValid    <= 1'b0;
			readPending <= 1'b0;
		end else begin
			readPending <= o_stencilReadSig;
			if (o_stencilReadSig) begin
				curValid <= 1'b1;
			end else if (!i_readReq) begin
				// Outside a scan the held word is stale
				curValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_stencilReadSig) begin
			curAdr <= i_nextBlockAdr;
		end
		if (readPending) begin
			stencilStore <= i_stencilReadValue;
		end
	end

	// Fresh data bypasses the store
	assign stencilMux = readPending ? i_stencilReadValue : stencilStore;
	assign lane       = {i_pixX[3:1], 1'b0};
	assign o_maskL    = stencilMux[lane];
	assign o_maskR    = stencilMux[lane+4'd1];

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
+incdir+tb
common/renderPkg.sv
raster/rectScanner.sv
raster/blockGather.sv
src/stencilMaskReader.sv
src/memWriteSequencer.sv
src/renderControl.sv
src/rectRenderTop.sv
tb/rectRenderTb.sv

// File: tb/rectRenderTbTasks.svh
/*
 * Compare tasks and directed tests, included inside the testbench module.
 */
`ifndef RECT_RENDER_TB_TASKS_SVH
`define RECT_RENDER_TB_TASKS_SVH

// ------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------
task automatic checkFlag(input string what, input int expVal, input int gotVal);
	checkCount++;
	if (gotVal !== expVal) begin
		errorCount++;
		$display("ERR @%0t: %s expected %0d got %0d", $time, what, expVal, gotVal);
	end
endtask

task automatic checkPixel(input string what, input logic [`RENDER_PIX_W-1:0] expVal,
		input logic [`RENDER_PIX_W-1:0] gotVal);
	checkCount++;
	if (gotVal !== expVal) begin
		errorCount++;
		$display("ERR @%0t: %s expected %h got %h", $time, what, expVal, gotVal);
	end
endtask

// Data only counts in the lanes the mask enables
task automatic checkMemReq(input renderPkg::memReq_t expVal, input renderPkg::memReq_t gotVal,
		input string what);
	logic [`RENDER_BLOCK_W-1:0] laneBits;
	int                         lane;
	laneBits = '0;
	for (lane = 0; lane < `RENDER_BLOCK_PIX; lane++) begin
		if (expVal.mask[lane]) laneBits[lane*`RENDER_PIX_W +: `RENDER_PIX_W] = '1;
	end
	checkCount++;
	if (gotVal.adr !== expVal.adr || gotVal.mask !== expVal.mask ||
			(gotVal.data & laneBits) !== (expVal.data & laneBits)) begin
		errorCount++;
		$display("ERR @%0t: %s adr %h/%h mask %h/%h (expected/got)", $time, what,
			expVal.adr, gotVal.adr, expVal.mask, gotVal.mask);
	end
endtask

// ------------------------------------------------------------
// One render from the table against the model
// ------------------------------------------------------------
task automatic renderAndCompare(input int idx);
	int i;
	expQ.delete();
	gotQ.delete();
	activeCycles = 0;
	buildExpected(testCmd[idx], testArea[idx], testCheck[idx]);
	@(negedge clk);
	cmd       = testCmd[idx];
	area      = testArea[idx];
	checkMask = testCheck[idx];
	busyMode  = testBusy[idx];
	start     = 1'b1;
	@(negedge clk);
	start = 1'b0;
	while (!active) @(negedge clk);
	while (active) @(negedge clk);
	checkFlag("block writes", expQ.size(), gotQ.size());
	for (i = 0; i < expQ.size() && i < gotQ.size(); i++) begin
		checkMemReq(expQ[i], gotQ[i], "block write");
	end
endtask

// ------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------
task automatic insideRectWrites();
	renderAndCompare(0);
	// Three blocks on each of two rows
	checkFlag("inside writes", 6, gotQ.size());
endtask

task automatic clippedRectWrites();
	renderAndCompare(1);
	// Pixels 33..47 then 48..50 on each row
	if (gotQ.size() == 4) begin
		checkFlag("left partial mask", 16'hFFFE, gotQ[0].mask);
		checkFlag("right partial mask", 16'h0007, gotQ[1].mask);
	end
endtask

task automatic emptyRectSkipped();
	renderAndCompare(2);
	checkFlag("active cycles outside", 2, activeCycles);
	renderAndCompare(3);
	checkFlag("active cycles reversed", 2, activeCycles);
endtask

task automatic stencilMaskSkip();
	int i;
	renderAndCompare(4);
	renderAndCompare(5);
	for (i = 0; i < gotQ.size(); i++) begin
		checkFlag("full mask without check", 16'hFFFF, gotQ[i].mask);
	end
endtask

task automatic busyBackPressure();
	renderPkg::rectCmd_t          c;
	int                           cx0, cy0, cx1, cy1, x, y, key, written;
	logic [`RENDER_BLOCK_PIX-1:0] sten;
	c = testCmd[6];
	for (key = 0; key < 131072; key++) vram[key] = '0;
	laneWrites = 0;
	renderAndCompare(6);
	clipRect(c, testArea[6], cx0, cy0, cx1, cy1);
	written = 0;
	for (y = cy0; y <= cy1; y++) begin
		for (x = cx0; x <= cx1; x++) begin
			key  = pixKey(y, x);
			sten = stencilWord({y[8:0], x[9:4]});
			if (testCheck[6] && sten[x % 16]) begin
				checkFlag("masked pixel untouched", 0, vram[key][`RENDER_PIX_W]);
			end else begin
				written++;
				checkFlag("pixel written", 1, vram[key][`RENDER_PIX_W]);
				checkPixel("VRAM pixel", {c.setMask, c.color}, vram[key][`RENDER_PIX_W-1:0]);
			end
		end
	end
	// Any duplicated block would write its lanes twice
	checkFlag("lanes written", written, laneWrites);
endtask

task automatic restartAfterDrain();
	renderAndCompare(7);
endtask

`endif

// File: tb/rectRenderTb.sv
/*
 * Testbench for the rectangle fill renderer.
 * Models the stencil port and a VRAM behind the memory port, then runs directed tests.
 */
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module rectRenderTb;

	localparam int NUM_TESTS = 8;

	// ------------------------------------------------------------
	// DUT signals
	// ------------------------------------------------------------
	logic                           clk;
	logic                           nrst;
	logic                           start;
	renderPkg::rectCmd_t            cmd;
	renderPkg::drawArea_t           area;
	logic                           checkMask;
	logic                           active;
	logic                           stencilReadSig;
	logic [`RENDER_BLOCK_ADR_W-1:0] stencilReadAdr;
	logic [`RENDER_BLOCK_PIX-1:0]   stencilReadValue;
	logic                           command;
	logic                           write;
	renderPkg::memReq_t             memReq;
	logic                           busy;

	// One table entry per render
	renderPkg::rectCmd_t  testCmd [NUM_TESTS];
	renderPkg::drawArea_t testArea [NUM_TESTS];
	logic                 testCheck [NUM_TESTS];
	logic                 testBusy [NUM_TESTS];

	// Expected and accepted block writes of the current render
	renderPkg::memReq_t expQ [$];
	renderPkg::memReq_t gotQ [$];

	// VRAM model, written flag on top of the pixel
	logic [`RENDER_PIX_W:0] vram [0:131071];
	int                     laneWrites = 0;

	int                             checkCount = 0;
	int                             errorCount = 0;
	int                             cycles = 0;
	int                             cycleLimit = 200;
	int                             activeCycles = 0;
	logic                           stencilPending = 1'b0;
	logic [`RENDER_BLOCK_ADR_W-1:0] stencilAdr = '0;
	logic                           busyMode = 1'b0;
	logic                           busyLevel = 1'b0;
	int                             busyRun = 0;
	logic                           heldPending = 1'b0;
	renderPkg::memReq_t             heldReq;
	logic [31:0]                    junk;

	rectRenderTop i_rectRenderTop (
		.i_clk              (clk),
		.i_nrst             (nrst),
		.i_start            (start),
		.i_cmd              (cmd),
		.i_area             (area),
		.i_checkMask        (checkMask),
		.o_active           (active),
		.o_stencilReadSig   (stencilReadSig),
		.o_stencilReadAdr   (stencilReadAdr),
		.i_stencilReadValue (stencilReadValue),
		.o_command          (command),
		.o_write            (write),
		.o_memReq           (memReq),
		.i_busy             (busy)
	);

	always #5 clk = ~clk;

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------

	// Stencil content, mixing every address bit
	function automatic logic [`RENDER_BLOCK_PIX-1:0] stencilWord(
			input logic [`RENDER_BLOCK_ADR_W-1:0] adr);
		return {adr[7:0], adr[14:7]} ^ 16'h5A3C;
	endfunction

	function automatic int pixKey(input int y, input int x);
		return ((y & 127) << 10) | (x & 1023);
	endfunction

	function automatic void clipRect(input renderPkg::rectCmd_t c,
			input renderPkg::drawArea_t a, output int cx0, output int cy0,
			output int cx1, output int cy1);
		cx0 = int'($signed(c.x0));
		cy0 = int'($signed(c.y0));
		cx1 = int'($signed(c.x1));
		cy1 = int'($signed(c.y1));
		if (cx0 < int'(a.x0)) cx0 = int'(a.x0);
		if (cy0 < int'(a.y0)) cy0 = int'(a.y0);
		if (cx1 > int'(a.x1)) cx1 = int'(a.x1);
		if (cy1 > int'(a.y1)) cy1 = int'(a.y1);
	endfunction

	function automatic int pairsOf(input int idx);
		int cx0, cy0, cx1, cy1;
		clipRect(testCmd[idx], testArea[idx], cx0, cy0, cx1, cy1);
		if (cx1 < cx0 || cy1 < cy0) return 0;
		// Rows start on the even pixel at or left of the clipped edge
		return (cy1 - cy0 + 1) * ((cx1 - (cx0 & ~1)) / 2 + 1);
	endfunction

	function automatic renderPkg::rectCmd_t makeCmd(input int x0, input int y0, input int x1,
			input int y1, input logic [`RENDER_COLOR_W-1:0] color, input logic setMask);
		renderPkg::rectCmd_t c;
		c.x0      = x0[`RENDER_COORD_W-1:0];
		c.y0      = y0[`RENDER_COORD_W-1:0];
		c.x1      = x1[`RENDER_COORD_W-1:0];
		c.y1      = y1[`RENDER_COORD_W-1:0];
		c.color   = color;
		c.setMask = setMask;
		return c;
	endfunction

	function automatic renderPkg::drawArea_t makeArea(input int x0, input int y0, input int x1,
			input int y1);
		renderPkg::drawArea_t a;
		a.x0 = x0[`RENDER_AREA_W-1:0];
		a.y0 = y0[`RENDER_AREA_W-1:0];
		a.x1 = x1[`RENDER_AREA_W-1:0];
		a.y1 = y1[`RENDER_AREA_W-1:0];
		return a;
	endfunction

	// Row-major block writes, one per block and row with any pixel left after the mask
	task automatic buildExpected(input renderPkg::rectCmd_t c, input renderPkg::drawArea_t a,
			input logic chk);
		renderPkg::memReq_t         req;
		int                         cx0, cy0, cx1, cy1, y, blk, x;
		logic [`RENDER_BLOCK_PIX-1:0] sten;
		clipRect(c, a, cx0, cy0, cx1, cy1);
		for (y = cy0; y <= cy1; y++) begin
			for (blk = cx0 / 16; blk <= cx1 / 16; blk++) begin
				req     = '0;
				req.adr = {y[8:0], blk[5:0]};
				sten    = stencilWord(req.adr);
				for (x = blk * 16; x < blk * 16 + 16; x++) begin
					if (x >= cx0 && x <= cx1 && !(chk && sten[x % 16])) begin
						req.mask[x % 16] = 1'b1;
						req.data[(x % 16)*`RENDER_PIX_W +: `RENDER_PIX_W] = {c.setMask, c.color};
					end
				end
				if (req.mask != '0) expQ.push_back(req);
			end
		end
	endtask

	task automatic storeBlock(input renderPkg::memReq_t req);
		int lane, key;
		for (lane = 0; lane < `RENDER_BLOCK_PIX; lane++) begin
			if (req.mask[lane]) begin
				key       = pixKey(int'(req.adr[14:6]), int'(req.adr[5:0]) * 16 + lane);
				vram[key] = {1'b1, req.data[lane*`RENDER_PIX_W +: `RENDER_PIX_W]};
				laneWrites++;
			end
		end
	endtask

	task automatic fillTestTable();
		int i;
		for (i = 0; i < NUM_TESTS; i++) begin
			testArea[i]  = makeArea(0, 0, 639, 479);
			testCheck[i] = 1'b0;
			testBusy[i]  = 1'b0;
		end
		// Inside, three blocks over two rows
		testCmd[0]   = makeCmd(20, 10, 55, 11, 15'h1234, 1'b0);
		// Negative corner, odd clipped edges
		testCmd[1]   = makeCmd(-7, -3, 100, 1, 15'h2A5F, 1'b1);
		testArea[1]  = makeArea(33, 0, 50, 300);
		// Right of the draw area, then X1 below X0
		testCmd[2]   = makeCmd(700, 10, 800, 20, 15'h0F0F, 1'b0);
		testCmd[3]   = makeCmd(50, 10, 40, 12, 15'h0F0F, 1'b0);
		// Same rectangle with and without mask check
		testCmd[4]   = makeCmd(0, 20, 31, 21, 15'h7C1F, 1'b0);
		testCheck[4] = 1'b1;
		testCmd[5]   = testCmd[4];
		// Long run under random busy
		testCmd[6]   = makeCmd(100, 30, 259, 33, 15'h03E0, 1'b1);
		testCheck[6] = 1'b1;
		testBusy[6]  = 1'b1;
		testCmd[7]   = makeCmd(8, 40, 23, 40, 15'h5555, 1'b0);
	endtask

	// ------------------------------------------------------------
	// Memory port, stencil port and watchdog
	// ------------------------------------------------------------
	always @(posedge clk) begin
		cycles++;
		if (active) activeCycles++;
		// A pending command must not move until accepted
		if (heldPending) begin
			checkFlag("command held", 1, command);
			checkMemReq(heldReq, memReq, "held request");
		end
		if (command) checkFlag("write with command", 1, write);
		heldPending = command && busy;
		heldReq     = memReq;
		if (command && !busy) begin
			gotQ.push_back(memReq);
			storeBlock(memReq);
		end
		stencilPending <= stencilReadSig;
		stencilAdr     <= stencilReadAdr;
		if (cycles > cycleLimit) begin
			$display("Timeout: the DUT did not finish within %0d cycles", cycleLimit);
			$display("TEST FAILED");
			$finish;
		end
	end

	always @(negedge clk) begin
		junk = $urandom;
		// Garbage outside the answer cycle
		stencilReadValue = stencilPending ? stencilWord(stencilAdr) : junk[15:0];
		if (!busyMode) begin
			busy = 1'b0;
		end else begin
			if (busyRun == 0) begin
				busyLevel = $urandom % 2;
				busyRun   = $urandom % 16 + 1;
			end
			busyRun--;
			busy = busyLevel;
		end
	end

	`include "rectRenderTbTasks.svh"

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		int idx;
		junk             = $urandom(9);
		clk              = 1'b0;
		nrst             = 1'b0;
		start            = 1'b0;
		cmd              = '0;
		area             = '0;
		checkMask        = 1'b0;
		stencilReadValue = '0;
		busy             = 1'b0;
		fillTestTable();
		for (idx = 0; idx < NUM_TESTS; idx++) begin
			cycleLimit += 4 * pairsOf(idx);
		end
		repeat (2) @(negedge clk);
		checkFlag("o_active in reset", 0, active);
		checkFlag("o_command in reset", 0, command);
		checkFlag("o_stencilReadSig in reset", 0, stencilReadSig);
		nrst = 1'b1;

		insideRectWrites();
		clippedRectWrites();
		emptyRectSkipped();
		stencilMaskSkip();
		busyBackPressure();
		restartAfterDrain();

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
